/* Bender.yml */
package:
  name: riscv_core

sources:
  # Packages before their users
  - files:
      - hw/riscv_isa_pkg.sv
      - hw/riscv_pipe_pkg.sv
      - hw/riscv_idex_if.sv
      - hw/riscv_rf.sv
      - hw/riscv_id.sv
      - hw/riscv_ex.sv
      - hw/riscv_core.sv

  - target: test
    files:
      - verif/core_checker.sv
      - verif/tb_riscv_core.sv

/* hw/riscv_core.sv */
// Core top level: input register, decode, execute and integer register file
`timescale 1ns/1ns

module riscv_core #(
  parameter int XLEN = 32
)
(
  input  logic                           clk_i,
  input  logic                           arst_n_i,

  // Fetched instructions, one per strobe
  input  logic                           insn_valid_i,
  input  logic [riscv_isa_pkg::ILEN-1:0] insn_i,

  // Every register write
  output logic                           wb_valid_o,
  output riscv_pipe_pkg::rsd_t           wb_dst_o,
  output logic [XLEN-1:0]                wb_r_o
);

  import riscv_isa_pkg::*;
  import riscv_pipe_pkg::*;

  logic            pd_valid;
  logic [ILEN-1:0] pd_insn;
  rsd_t            id_rs1, id_rs2;
  logic [XLEN-1:0] rf_srcv1, rf_srcv2;
  logic [XLEN-1:0] ex_r;

  riscv_idex_if #(.XLEN(XLEN)) idex ();

  //////////////////////////////
  // Input register
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      pd_valid <= 1'b0;
    else
      pd_valid <= insn_valid_i;
  end

  always_ff @(posedge clk_i)
    pd_insn <= insn_i;

  // Decode, reads RF combinationally
  riscv_id #(
    .XLEN       ( XLEN       ) )
  id_unit (
    .clk_i      ( clk_i      ),
    .arst_n_i   ( arst_n_i   ),
    .pd_valid_i ( pd_valid   ),
    .pd_insn_i  ( pd_insn    ),
    .id_rs1_o   ( id_rs1     ),
    .id_rs2_o   ( id_rs2     ),
    .rf_srcv1_i ( rf_srcv1   ),
    .rf_srcv2_i ( rf_srcv2   ),
    .ex_r_i     ( ex_r       ),
    .wb_valid_i ( wb_valid_o ),
    .wb_dst_i   ( wb_dst_o   ),
    .wb_r_i     ( wb_r_o     ),
    .idex       ( idex.id    ) );

  riscv_ex #(
    .XLEN       ( XLEN       ) )
  ex_unit (
    .clk_i      ( clk_i      ),
    .arst_n_i   ( arst_n_i   ),
    .idex       ( idex.ex    ),
    .ex_r_o     ( ex_r       ),
    .wb_valid_o ( wb_valid_o ),
    .wb_dst_o   ( wb_dst_o   ),
    .wb_r_o     ( wb_r_o     ) );

  // Write port fed straight from the write-back bus
  riscv_rf #(
    .XLEN        ( XLEN       ) )
  int_rf (
    .clk_i       ( clk_i      ),
    .arst_n_i    ( arst_n_i   ),
    .rf_src1_i   ( id_rs1     ),
    .rf_src2_i   ( id_rs2     ),
    .rf_src1_q_o ( rf_srcv1   ),
    .rf_src2_q_o ( rf_srcv2   ),
    .rf_dst_i    ( wb_dst_o   ),
    .rf_dst_d_i  ( wb_r_o     ),
    .rf_we_i     ( wb_valid_o ) );

endmodule

/* hw/riscv_ex.sv */
// Execute stage: ALU and the write-back register
`timescale 1ns/1ns

module riscv_ex #(
  parameter int XLEN = 32
)
(
  input  logic                 clk_i,
  input  logic                 arst_n_i,

  riscv_idex_if.ex             idex,

  output logic [XLEN-1:0]      ex_r_o,      // Combinational result, EX bypass
  output logic                 wb_valid_o,
  output riscv_pipe_pkg::rsd_t wb_dst_o,
  output logic [XLEN-1:0]      wb_r_o
);

  import riscv_isa_pkg::*;

  logic [XLEN-1:0] alu_r;

  //////////////////////////////
  // ALU
  always_comb
  begin
    case (idex.op)
      ALU_ADD: alu_r = idex.opa + idex.opb;
      ALU_SUB: alu_r = idex.opa - idex.opb;
      ALU_AND: alu_r = idex.opa & idex.opb;
      ALU_OR:  alu_r = idex.opa | idex.opb;
      ALU_XOR: alu_r = idex.opa ^ idex.opb;
      ALU_SLT: alu_r = {{(XLEN-1){1'b0}}, $signed(idex.opa) < $signed(idex.opb)};
      default: alu_r = '0;
    endcase
  end

  assign ex_r_o = alu_r;

  //////////////////////////////
  // Write-back register
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      wb_valid_o <= 1'b0;
    else
      wb_valid_o <= idex.valid && idex.we;   // Only real register writes
  end

  always_ff @(posedge clk_i)
  begin
    wb_dst_o <= idex.dst;
    wb_r_o   <= alu_r;
  end

endmodule

/* hw/riscv_id.sv */
// Decode stage: field split, ALU op decode, immediate, operand bypass, ID/EX register
`timescale 1ns/1ns

module riscv_id #(
  parameter int XLEN = 32
)
(
  input  logic                         clk_i,
  input  logic                         arst_n_i,

  input  logic                         pd_valid_i,
  input  logic [riscv_isa_pkg::ILEN-1:0] pd_insn_i,

  output riscv_pipe_pkg::rsd_t         id_rs1_o,   // To RF read ports
  output riscv_pipe_pkg::rsd_t         id_rs2_o,
  input  logic [XLEN-1:0]              rf_srcv1_i,
  input  logic [XLEN-1:0]              rf_srcv2_i,

  input  logic [XLEN-1:0]              ex_r_i,     // EX bypass
  input  logic                         wb_valid_i, // WB bypass
  input  riscv_pipe_pkg::rsd_t         wb_dst_i,
  input  logic [XLEN-1:0]              wb_r_i,

  riscv_idex_if.id                     idex
);

  import riscv_isa_pkg::*;
  import riscv_pipe_pkg::*;

  typedef enum logic [1:0] {
    BYP_RF,
    BYP_EX,
    BYP_WB
  } byp_src_t;

  localparam int IMM_W = IMM_HI - IMM_LO + 1;

  opcode_t         opcode;
  rsd_t            rs1, rs2, rd;
  logic [2:0]      funct3;
  logic            sub_bit;
  logic [5:0]      f7_rest;        // funct7 without the SUB bit
  logic            dec_ok;
  alu_op_t         dec_op;
  logic            is_imm;
  logic [XLEN-1:0] imm;
  byp_src_t        byp1, byp2;
  logic [XLEN-1:0] opa_nxt, rs2_val, opb_nxt;

  // Newest producer wins, x0 never bypassed
  function automatic byp_src_t byp_sel(input rsd_t src, input logic ex_v, input rsd_t ex_dst,
                                       input logic wb_v, input rsd_t wb_dst);
    if (src != '0 && ex_v && ex_dst == src)
      return BYP_EX;
    else if (src != '0 && wb_v && wb_dst == src)
      return BYP_WB;
    else
      return BYP_RF;
  endfunction

  //////////////////////////////
  // Fields
  assign opcode  = opcode_t'(pd_insn_i[OPC_HI:OPC_LO]);
  assign rd      = pd_insn_i[RD_HI:RD_LO];
  assign rs1     = pd_insn_i[RS1_HI:RS1_LO];
  assign rs2     = pd_insn_i[RS2_HI:RS2_LO];
  assign funct3  = pd_insn_i[F3_HI:F3_LO];
  assign sub_bit = pd_insn_i[FUNCT7_SUB_BIT];
  assign f7_rest = {pd_insn_i[F7_HI], pd_insn_i[FUNCT7_SUB_BIT-1:F7_LO]};
  assign imm     = {{(XLEN-IMM_W){pd_insn_i[IMM_HI]}}, pd_insn_i[IMM_HI:IMM_LO]};

  assign id_rs1_o = rs1;
  assign id_rs2_o = rs2;

  always_comb
  begin
    dec_ok = 1'b1;
    is_imm = 1'b0;
    case (funct3)
      F3_ADD_SUB: dec_op = ALU_ADD;
      F3_SLT:     dec_op = ALU_SLT;
      F3_XOR:     dec_op = ALU_XOR;
      F3_OR:      dec_op = ALU_OR;
      F3_AND:     dec_op = ALU_AND;
      default:
      begin
        dec_op = ALU_ADD;
        dec_ok = 1'b0;                   // Shifts, SLTU
      end
    endcase

    case (opcode)
      OPC_OP:
      begin
        // Only funct7 0000000, or 0100000 with ADD/SUB
        if (f7_rest != '0 || (sub_bit && funct3 != F3_ADD_SUB))
          dec_ok = 1'b0;
        else if (sub_bit)
          dec_op = ALU_SUB;
      end
      OPC_OP_IMM: is_imm = 1'b1;
      default:    dec_ok = 1'b0;         // Bubble
    endcase
  end

  //////////////////////////////
  // Operand bypass
  assign byp1 = byp_sel(rs1, idex.valid && idex.we, idex.dst, wb_valid_i, wb_dst_i);
  assign byp2 = byp_sel(rs2, idex.valid && idex.we, idex.dst, wb_valid_i, wb_dst_i);

  always_comb
  begin
    case (byp1)
      BYP_EX:  opa_nxt = ex_r_i;
      BYP_WB:  opa_nxt = wb_r_i;
      default: opa_nxt = rf_srcv1_i;
    endcase
    case (byp2)
      BYP_EX:  rs2_val = ex_r_i;
      BYP_WB:  rs2_val = wb_r_i;
      default: rs2_val = rf_srcv2_i;
    endcase
  end

  assign opb_nxt = is_imm ? imm : rs2_val;

  //////////////////////////////
  // ID/EX register
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      idex.valid <= 1'b0;
      idex.we    <= 1'b0;
    end
    else
    begin
      idex.valid <= pd_valid_i && dec_ok;
      idex.we    <= pd_valid_i && dec_ok && rd != '0;   // x0 writes dropped
    end
  end

  always_ff @(posedge clk_i)
  begin
    idex.op  <= dec_op;
    idex.dst <= rd;
    idex.opa <= opa_nxt;
    idex.opb <= opb_nxt;
  end

endmodule

/* hw/riscv_idex_if.sv */
// Decode to execute interface carrying one decoded instruction per cycle
`timescale 1ns/1ns

interface riscv_idex_if #(
  parameter int XLEN = 32
);

  import riscv_isa_pkg::*;
  import riscv_pipe_pkg::*;

  logic            valid;   // Slot holds an instruction
  alu_op_t         op;
  rsd_t            dst;
  logic [XLEN-1:0] opa;     // Operands after bypass
  logic [XLEN-1:0] opb;
  logic            we;      // Writes a register other than x0

  // Decode side
  modport id (
    output valid, op, dst, opa, opb, we
  );

  // Execute side
  modport ex (
    input  valid, op, dst, opa, opb, we
  );

endinterface

/* hw/riscv_isa_pkg.sv */
// RV32I encodings: instruction width, major opcodes, funct3 values, field positions, ALU ops
package riscv_isa_pkg;

  localparam int ILEN = 32;               // Instruction width

  //////////////////////////////
  // Major opcodes
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,              // Register-register
    OPC_OP_IMM = 7'b0010011               // Register-immediate
  } opcode_t;

  // funct3 values shared by OP and OP_IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  localparam int FUNCT7_SUB_BIT = 30;     // Selects SUB over ADD

  //////////////////////////////
  // Field positions
  localparam int OPC_HI = 6;
  localparam int OPC_LO = 0;
  localparam int RD_HI  = 11;
  localparam int RD_LO  = 7;
  localparam int F3_HI  = 14;
  localparam int F3_LO  = 12;
  localparam int RS1_HI = 19;
  localparam int RS1_LO = 15;
  localparam int RS2_HI = 24;
  localparam int RS2_LO = 20;
  localparam int F7_HI  = 31;
  localparam int F7_LO  = 25;
  localparam int IMM_HI = 31;             // I-type immediate
  localparam int IMM_LO = 20;

  // Operations the execute stage knows
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_t;

endpackage

/* hw/riscv_pipe_pkg.sv */
// Pipeline types: register index width, register index type, register count
package riscv_pipe_pkg;

  //////////////////////////////
  // Integer register file

  localparam int RSD_W   = 5;             // Index width
  localparam int REG_CNT = 1 << RSD_W;    // x0 included

  // Source or destination register index
  typedef logic [RSD_W-1:0] rsd_t;

endpackage

/* hw/riscv_rf.sv */
// Integer register file, two combinational read ports and one write port, x0 fixed at zero
`timescale 1ns/1ns

module riscv_rf #(
  parameter int XLEN = 32
)
(
  input  logic                 clk_i,
  input  logic                 arst_n_i,

  input  riscv_pipe_pkg::rsd_t rf_src1_i,
  input  riscv_pipe_pkg::rsd_t rf_src2_i,
  output logic [XLEN-1:0]      rf_src1_q_o,
  output logic [XLEN-1:0]      rf_src2_q_o,

  input  riscv_pipe_pkg::rsd_t rf_dst_i,
  input  logic [XLEN-1:0]      rf_dst_d_i,
  input  logic                 rf_we_i
);

  import riscv_pipe_pkg::*;

  logic [XLEN-1:0] regs [1:REG_CNT-1];    // No storage for x0

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      for (int i = 1; i < REG_CNT; i++)
        regs[i] <= '0;
    end
    else if (rf_we_i && rf_dst_i != '0)
      regs[rf_dst_i] <= rf_dst_d_i;
  end

  // Reads of x0 give zero
  assign rf_src1_q_o = (rf_src1_i == '0) ? '0 : regs[rf_src1_i];
  assign rf_src2_q_o = (rf_src2_i == '0) ? '0 : regs[rf_src2_i];

endmodule

/* project.f */
hw/riscv_isa_pkg.sv
hw/riscv_pipe_pkg.sv
hw/riscv_idex_if.sv
hw/riscv_rf.sv
hw/riscv_id.sv
hw/riscv_ex.sv
hw/riscv_core.sv
verif/core_checker.sv
verif/tb_riscv_core.sv

/* verif/core_checker.sv */
// Write-back checker: register file model, expected write queue, value and latency compare
`timescale 1ns/1ns

module core_checker #(
  parameter int XLEN = 32
)
(
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  input  logic                           insn_valid_i,
  input  logic [riscv_isa_pkg::ILEN-1:0] insn_i,
  input  logic                           wb_valid_i,
  input  riscv_pipe_pkg::rsd_t           wb_dst_i,
  input  logic [XLEN-1:0]                wb_r_i,
  output int                             pending_o,   // Writes still expected
  output int                             err_cnt_o,
  output int                             chk_cnt_o
);

  import riscv_isa_pkg::*;
  import riscv_pipe_pkg::*;

  logic [XLEN-1:0] model_rf [REG_CNT];
  rsd_t            exp_rd  [$];
  logic [XLEN-1:0] exp_val [$];
  int              exp_cyc [$];    // Edge that sampled the instruction
  int              cyc;

  initial
  begin
    cyc       = 0;
    pending_o = 0;
    err_cnt_o = 0;
    chk_cnt_o = 0;
    for (int i = 0; i < REG_CNT; i++)
      model_rf[i] = '0;
  end

  //////////////////////////////
  // Program-order model
  task automatic predict_write(input logic [ILEN-1:0] insn);
    opcode_t         opc;
    rsd_t            rd;
    logic [2:0]      f3;
    logic [XLEN-1:0] a, b, r;
    opc = opcode_t'(insn[OPC_HI:OPC_LO]);
    rd  = insn[RD_HI:RD_LO];
    f3  = insn[F3_HI:F3_LO];
    a   = model_rf[insn[RS1_HI:RS1_LO]];
    if (opc == OPC_OP)
      b = model_rf[insn[RS2_HI:RS2_LO]];
    else
      b = {{(XLEN-12){insn[IMM_HI]}}, insn[IMM_HI:IMM_LO]};
    r = '0;
    case (f3)
      F3_ADD_SUB: r = (opc == OPC_OP && insn[FUNCT7_SUB_BIT]) ? a - b : a + b;
      F3_SLT:     r[0] = $signed(a) < $signed(b);
      F3_XOR:     r = a ^ b;
      F3_OR:      r = a | b;
      F3_AND:     r = a & b;
      default:    r = '0;
    endcase
    if (rd != '0)                  // x0 never reported
    begin
      model_rf[rd] = r;
      exp_rd.push_back(rd);
      exp_val.push_back(r);
      exp_cyc.push_back(cyc);
    end
    pending_o = exp_rd.size();
  endtask

  task automatic check_write();
    rsd_t            rd;
    logic [XLEN-1:0] val;
    int              c0;
    rd  = exp_rd.pop_front();
    val = exp_val.pop_front();
    c0  = exp_cyc.pop_front();
    chk_cnt_o++;
    if (wb_dst_i !== rd || wb_r_i !== val)
    begin
      $display("** Error @%0t ns: write x%0d = %h, expected x%0d = %h",
               $time, wb_dst_i, wb_r_i, rd, val);
      err_cnt_o++;
    end
    if (cyc != c0 + 2)
    begin
      $display("** Error @%0t ns: write to x%0d came %0d cycles after sampling, expected 2",
               $time, rd, cyc - c0);
      err_cnt_o++;
    end
    pending_o = exp_rd.size();
  endtask

  always @(posedge clk_i)
  begin
    cyc = cyc + 1;
    if (arst_n_i && insn_valid_i)
      predict_write(insn_i);
  end

  // Outputs settled by the falling edge
  always @(negedge clk_i)
  begin
    if (!arst_n_i)
    begin
      if (wb_valid_i !== 1'b0)
      begin
        $display("** Error @%0t ns: write-back strobe not low during reset", $time);
        err_cnt_o++;
      end
    end
    else if (wb_valid_i === 1'b1)
    begin
      if (exp_rd.size() == 0)
      begin
        $display("** Error @%0t ns: write to x%0d with no write expected", $time, wb_dst_i);
        err_cnt_o++;
      end
      else
        check_write();
    end
  end

endmodule

/* verif/tb_riscv_core.sv */
// Testbench top with clock and reset, random ALU instruction stimulus, DUT and checker instances
`timescale 1ns/1ns

module tb_riscv_core;

  import riscv_isa_pkg::*;
  import riscv_pipe_pkg::*;

  localparam int XLEN = 32;

  logic            clk_i;
  logic            arst_n_i;
  logic            insn_valid_i;
  logic [ILEN-1:0] insn_i;
  logic            wb_valid_o;
  rsd_t            wb_dst_o;
  logic [XLEN-1:0] wb_r_o;
  int              pending, err_cnt, chk_cnt;
  int              pass_cnt, fail_cnt;
  integer          seed;
  bit              stuck;        // Queue failed to drain

  riscv_core #(.XLEN(XLEN)) u_riscv_core (
    .clk_i (clk_i), .arst_n_i (arst_n_i), .insn_valid_i (insn_valid_i), .insn_i (insn_i),
    .wb_valid_o (wb_valid_o), .wb_dst_o (wb_dst_o), .wb_r_o (wb_r_o));

  core_checker #(.XLEN(XLEN)) u_checker (
    .clk_i (clk_i), .arst_n_i (arst_n_i), .insn_valid_i (insn_valid_i), .insn_i (insn_i),
    .wb_valid_i (wb_valid_o), .wb_dst_i (wb_dst_o), .wb_r_i (wb_r_o),
    .pending_o (pending), .err_cnt_o (err_cnt), .chk_cnt_o (chk_cnt));

  initial
  begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  //////////////////////////////
  // Encoding and stimulus helpers

  // sel 0..4 ADD SLT XOR OR AND, 5 SUB, 6..10 SLTI XORI ORI ANDI ADDI
  function automatic logic [ILEN-1:0] alu_insn(input int sel, input rsd_t rd, input rsd_t rs1,
                                               input rsd_t rs2, input logic [11:0] imm);
    logic [2:0] f3;
    case (sel % 5)
      0:       f3 = F3_ADD_SUB;
      1:       f3 = F3_SLT;
      2:       f3 = F3_XOR;
      3:       f3 = F3_OR;
      default: f3 = F3_AND;
    endcase
    if (sel >= 6)
      return {imm, rs1, f3, rd, OPC_OP_IMM};
    else
      return {1'b0, sel == 5, 5'b0, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic rsd_t rand_reg();
    return rsd_t'(1 + rand_below(REG_CNT - 1));   // Never x0
  endfunction

  function automatic logic [11:0] rand_imm();
    return 12'($random(seed));
  endfunction

  task automatic send(input logic [ILEN-1:0] insn);
    @(negedge clk_i);
    insn_valid_i = 1'b1;
    insn_i       = insn;
  endtask

  task automatic idle();
    @(negedge clk_i);
    insn_valid_i = 1'b0;
    insn_i       = '0;
  endtask

  // Wait until every expected write has come back
  task automatic drain();
    int n;
    idle();
    n = 0;
    while (pending != 0 && n < 100)
    begin
      @(posedge clk_i);
      n++;
    end
    if (pending != 0)
      stuck = 1'b1;
    repeat (3) @(posedge clk_i);     // Catch late stray writes
  endtask

  task automatic report(input string name, input int err0);
    if (stuck)
      $display("Test %s: failed, write-back queue still holds %0d entries", name, pending);
    else if (err_cnt != err0)
      $display("Test %s: failed with %0d errors", name, err_cnt - err0);
    else
      $display("Test %s: ok", name);
    if (stuck || err_cnt != err0)
      fail_cnt++;
    else
      pass_cnt++;
    stuck = 1'b0;
  endtask

  //////////////////////////////
  // Test sequence
  initial
  begin
    rsd_t rd, p1, p2;
    int   err0;
    seed = 81;
    stuck = 1'b0;
    pass_cnt = 0;
    fail_cnt = 0;
    arst_n_i = 1'b0;
    insn_valid_i = 1'b0;
    insn_i = '0;
    repeat (4) @(negedge clk_i);
    arst_n_i = 1'b1;

    // Quiet pipeline, then read every register back via ADDI rd, rd, 0
    repeat (4) idle();
    for (int r = 0; r < REG_CNT; r++)
      send(alu_insn(10, rsd_t'(r), rsd_t'(r), '0, '0));
    drain();
    report("reset state", 0);

    err0 = err_cnt;
    for (int i = 0; i < 30; i++)
    begin
      p1 = rand_reg();
      p2 = rand_reg();
      send(alu_insn(10, p1, '0, '0, rand_imm()));   // Load operands
      send(alu_insn(10, p2, '0, '0, rand_imm()));
      for (int s = 0; s < 11; s++)
        send(alu_insn(s, rand_reg(), p1, p2, rand_imm()));
    end
    drain();
    report("ALU operations", err0);

    // Sources are the last one or two destinations
    err0 = err_cnt;
    p1 = rand_reg();
    p2 = rand_reg();
    for (int i = 0; i < 300; i++)
    begin
      rd = rand_reg();
      if (rand_below(2) == 0)
        send(alu_insn(rand_below(11), rd, p1, p2, rand_imm()));
      else
        send(alu_insn(rand_below(11), rd, p2, p1, rand_imm()));
      p2 = p1;
      p1 = rd;
    end
    drain();
    report("bypass", err0);

    err0 = err_cnt;
    for (int i = 0; i < 40; i++)
    begin
      send(alu_insn(rand_below(11), '0, rand_reg(), rand_reg(), rand_imm()));
      send(alu_insn(rand_below(11), rand_reg(), '0, rand_reg(), rand_imm()));
      send(alu_insn(rand_below(6), rand_reg(), rand_reg(), '0, rand_imm()));
    end
    drain();
    report("x0 handling", err0);

    err0 = err_cnt;
    for (int i = 0; i < 10; i++)
    begin
      send(alu_insn(rand_below(11), rand_reg(), rand_reg(), rand_reg(), rand_imm()));
      drain();                        // Isolated instruction
    end
    report("latency", err0);

    err0 = err_cnt;
    for (int i = 0; i < 2000; i++)
    begin
      if (rand_below(4) == 0)
        idle();
      send(alu_insn(rand_below(11), rsd_t'(rand_below(REG_CNT)), rsd_t'(rand_below(REG_CNT)),
                    rsd_t'(rand_below(REG_CNT)), rand_imm()));
    end
    drain();
    report("random mix", err0);

    $display("Tests: %0d passed, %0d failed, %0d writes checked, %0d errors",
             pass_cnt, fail_cnt, chk_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule
